/* rtl/isp_config.svh */
`ifndef ISP_CONFIG_SVH
`define ISP_CONFIG_SVH

// picture store in DRAM
`define ISP_NUM_PICS           16
`define ISP_DRAM_BASE          32'h0001_0000
`define ISP_PIC_STRIDE         32'd3072

// burst geometry, 16-byte beats
`define ISP_BEATS_PER_CHANNEL  64
`define ISP_NUM_CHANNELS       3
`define ISP_BURST_BEATS        192

// picture sum to average, 1024 pixels
`define ISP_AVG_SHIFT          10

`endif

/* rtl/isp_pkg.sv */
package isp_pkg;

    typedef enum logic [1:0] {
        ratio_quarter = 2'd0,
        ratio_half    = 2'd1,
        ratio_unity   = 2'd2,
        ratio_double  = 2'd3
    } ratio_mode_e;

    typedef enum logic [2:0] {
        st_idle,
        st_lookup,
        st_transfer,
        st_finish,
        st_respond
    } ctrl_state_e;

    // one DRAM beat, byte 0 in the low bits
    typedef logic [15:0][7:0] beat_t;

    typedef logic [3:0]  pic_no_t;
    typedef logic [17:0] sum_t;

    typedef struct packed {
        pic_no_t     pic_no;
        ratio_mode_e ratio;
    } request_t;

    // shared by ar and aw
    typedef struct packed {
        logic [31:0] addr;
        logic [7:0]  len;
        logic        valid;
    } axi_addr_t;

    typedef struct packed {
        beat_t data;
        logic  last;
        logic  valid;
    } axi_rdata_t;

    typedef struct packed {
        beat_t data;
        logic  last;
        logic  valid;
    } axi_wdata_t;

    // scaled stream out of the read port
    typedef struct packed {
        beat_t      data;
        logic [1:0] channel;
        logic       last;
        logic       valid;
    } pixel_beat_t;

endpackage

/* rtl/exposure_ctrl.sv */
`timescale 1ns/1ps
`include "isp_config.svh"

module exposure_ctrl (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  in_valid,
    input  isp_pkg::request_t     in_req,
    input  logic                  write_done,
    input  logic                  sum_valid,
    input  isp_pkg::sum_t         sum,
    output logic                  start,
    output logic [31:0]           base_addr,
    output isp_pkg::ratio_mode_e  ratio,
    output logic                  out_valid,
    output logic [7:0]            out_data
);

    isp_pkg::ctrl_state_e      state;
    isp_pkg::ctrl_state_e      next_state;
    isp_pkg::request_t         req_q;
    isp_pkg::sum_t             sum_q;
    logic                      wr_seen;
    logic                      sum_seen;
    logic                      hit;
    logic                      both_done;
    logic [7:0]                avg;
    logic [7:0]                result_q;

    // last result per picture
    logic [7:0]                rec_data [`ISP_NUM_PICS];
    logic [`ISP_NUM_PICS-1:0]  rec_valid;

    // unity keeps the picture as is, so the old average still holds
    assign hit       = (req_q.ratio == isp_pkg::ratio_unity) && rec_valid[req_q.pic_no];
    assign both_done = (wr_seen || write_done) && (sum_seen || sum_valid);
    assign avg       = 8'(sum_q >> `ISP_AVG_SHIFT);

    assign base_addr = `ISP_DRAM_BASE + 32'(req_q.pic_no) * `ISP_PIC_STRIDE;
    assign ratio     = req_q.ratio;
    assign out_valid = (state == isp_pkg::st_respond);
    assign out_data  = result_q;

    // ========================================
    // sequencing
    // ========================================
    always_comb begin
        next_state = state;
        case (state)
            isp_pkg::st_idle:     if (in_valid) next_state = isp_pkg::st_lookup;
            isp_pkg::st_lookup:   next_state = hit ? isp_pkg::st_respond : isp_pkg::st_transfer;
            isp_pkg::st_transfer: if (both_done) next_state = isp_pkg::st_finish;
            isp_pkg::st_finish:   next_state = isp_pkg::st_respond;
            isp_pkg::st_respond:  next_state = isp_pkg::st_idle;
            default:              next_state = isp_pkg::st_idle;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= isp_pkg::st_idle;
            start    <= 1'b0;
            wr_seen  <= 1'b0;
            sum_seen <= 1'b0;
        end else begin
            state <= next_state;
            start <= (state == isp_pkg::st_lookup) && !hit;
            if (state == isp_pkg::st_lookup) begin
                wr_seen  <= 1'b0;
                sum_seen <= 1'b0;
            end else begin
                // completions arrive in either order
                if (write_done) wr_seen <= 1'b1;
                if (sum_valid) sum_seen <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == isp_pkg::st_idle && in_valid) begin
            req_q <= in_req;
        end
        if (sum_valid) begin
            sum_q <= sum;
        end
    end

    // ========================================
    // result record
    // ========================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rec_valid <= '0;
        end else if (state == isp_pkg::st_finish) begin
            rec_valid[req_q.pic_no] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (state == isp_pkg::st_finish) begin
            rec_data[req_q.pic_no] <= avg;
            result_q               <= avg;
        end else if (state == isp_pkg::st_lookup && hit) begin
            result_q <= rec_data[req_q.pic_no];
        end
    end

endmodule

/* rtl/dram_read_port.sv */
`timescale 1ns/1ps
`include "isp_config.svh"

module dram_read_port (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  start,
    input  logic [31:0]           base_addr,
    input  isp_pkg::ratio_mode_e  ratio,
    output isp_pkg::axi_addr_t    ar,
    input  logic                  arready,
    input  isp_pkg::axi_rdata_t   r,
    output logic                  rready,
    input  logic                  space,
    output isp_pkg::pixel_beat_t  pixel
);

    logic            ar_valid;
    logic [31:0]     ar_addr;
    logic            reading;
    logic            r_hs;
    logic [5:0]      beat_cnt;
    logic [1:0]      chan_cnt;
    isp_pkg::beat_t  scaled;
    logic            pix_valid;
    isp_pkg::beat_t  pix_data;
    logic [1:0]      pix_chan;
    logic            pix_last;

    function automatic logic [7:0] scale_byte(input logic [7:0] b,
                                              input isp_pkg::ratio_mode_e m);
        case (m)
            isp_pkg::ratio_quarter: scale_byte = b >> 2;
            isp_pkg::ratio_half:    scale_byte = b >> 1;
            isp_pkg::ratio_double:  scale_byte = b[7] ? 8'hff : {b[6:0], 1'b0};
            default:                scale_byte = b;
        endcase
    endfunction

    assign ar     = '{addr: ar_addr, len: 8'(`ISP_BURST_BEATS - 1), valid: ar_valid};
    // hold off while the write side could not take another beat
    assign rready = reading && space;
    assign r_hs   = r.valid && rready;
    assign pixel  = '{data: pix_data, channel: pix_chan, last: pix_last, valid: pix_valid};

    always_comb begin
        for (int i = 0; i < 16; i++) begin
            scaled[i] = scale_byte(r.data[i], ratio);
        end
    end

    // ========================================
    // address and data channels
    // ========================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ar_valid <= 1'b0;
            reading  <= 1'b0;
        end else begin
            if (start) ar_valid <= 1'b1;
            else if (arready) ar_valid <= 1'b0;
            if (ar_valid && arready) reading <= 1'b1;
            else if (r_hs && r.last) reading <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            ar_addr <= base_addr;
        end
    end

    // beat position gives the colour channel
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            beat_cnt <= '0;
            chan_cnt <= '0;
        end else if (start) begin
            beat_cnt <= '0;
            chan_cnt <= '0;
        end else if (r_hs) begin
            beat_cnt <= beat_cnt + 6'd1;
            if (beat_cnt == 6'(`ISP_BEATS_PER_CHANNEL - 1)) begin
                chan_cnt <= (chan_cnt == 2'(`ISP_NUM_CHANNELS - 1)) ? 2'd0 : chan_cnt + 2'd1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pix_valid <= 1'b0;
        end else begin
            pix_valid <= r_hs;
        end
    end

    always_ff @(posedge clk) begin
        if (r_hs) begin
            pix_data <= scaled;
            pix_chan <= chan_cnt;
            pix_last <= r.last;
        end
    end

endmodule

/* rtl/dram_write_port.sv */
`timescale 1ns/1ps
`include "isp_config.svh"

module dram_write_port (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  start,
    input  logic [31:0]           base_addr,
    input  isp_pkg::pixel_beat_t  pixel,
    output logic                  space,
    output isp_pkg::axi_addr_t    aw,
    input  logic                  awready,
    output isp_pkg::axi_wdata_t   w,
    input  logic                  wready,
    input  logic                  bvalid,
    output logic                  bready,
    output logic                  write_done
);

    logic            aw_valid;
    logic [31:0]     aw_addr;
    logic            w_hs;
    logic            buf_valid;
    isp_pkg::beat_t  buf_data;
    logic            buf_last;

    assign aw = '{addr: aw_addr, len: 8'(`ISP_BURST_BEATS - 1), valid: aw_valid};
    assign w  = '{data: buf_data, last: buf_last, valid: buf_valid};

    assign w_hs = buf_valid && wready;

    // buffer free next cycle and no beat already on its way from the read port
    assign space = (!buf_valid || w_hs) && !pixel.valid;

    // responses are always taken
    assign bready     = 1'b1;
    assign write_done = bvalid && bready;

    // ========================================
    // write address
    // ========================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            aw_valid <= 1'b0;
        end else if (start) begin
            aw_valid <= 1'b1;
        end else if (awready) begin
            aw_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            aw_addr <= base_addr;
        end
    end

    // ========================================
    // one-beat holding buffer
    // ========================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            buf_valid <= 1'b0;
        end else if (pixel.valid) begin
            buf_valid <= 1'b1;
        end else if (w_hs) begin
            buf_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (pixel.valid) begin
            buf_data <= pixel.data;
            buf_last <= pixel.last;
        end
    end

endmodule

/* rtl/brightness_accumulator.sv */
`timescale 1ns/1ps

module brightness_accumulator (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  start,
    input  isp_pkg::pixel_beat_t  pixel,
    output logic                  sum_valid,
    output isp_pkg::sum_t         sum
);

    logic [6:0]     lane_q [16];
    logic [7:0]     add1_q [8];
    logic [8:0]     add2_q [4];
    logic [9:0]     add3_q [2];
    logic [10:0]    add4_q;
    logic [4:0]     vld_q;
    logic [4:0]     last_q;
    isp_pkg::sum_t  acc_q;

    assign sum = acc_q;

    // ========================================
    // stage control
    // ========================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vld_q     <= '0;
            last_q    <= '0;
            sum_valid <= 1'b0;
        end else begin
            vld_q     <= {vld_q[3:0], pixel.valid};
            last_q    <= {last_q[3:0], pixel.valid && pixel.last};
            // accumulator takes the final beat on this same edge
            sum_valid <= vld_q[4] && last_q[4];
        end
    end

    // ========================================
    // weighting and adder tree
    // ========================================
    always_ff @(posedge clk) begin
        // grey weights 1/4, 1/2, 1/4
        for (int i = 0; i < 16; i++) begin
            if (pixel.channel == 2'd1) begin
                lane_q[i] <= 7'(pixel.data[i] >> 1);
            end else begin
                lane_q[i] <= 7'(pixel.data[i] >> 2);
            end
        end
        for (int i = 0; i < 8; i++) begin
            add1_q[i] <= {1'b0, lane_q[2*i]} + {1'b0, lane_q[2*i+1]};
        end
        for (int i = 0; i < 4; i++) begin
            add2_q[i] <= {1'b0, add1_q[2*i]} + {1'b0, add1_q[2*i+1]};
        end
        for (int i = 0; i < 2; i++) begin
            add3_q[i] <= {1'b0, add2_q[2*i]} + {1'b0, add2_q[2*i+1]};
        end
        add4_q <= {1'b0, add3_q[0]} + {1'b0, add3_q[1]};
    end

    // picture sum, cleared per request
    always_ff @(posedge clk) begin
        if (start) begin
            acc_q <= '0;
        end else if (vld_q[4]) begin
            acc_q <= acc_q + 18'(add4_q);
        end
    end

endmodule

/* rtl/isp_exposure_top.sv */
`timescale 1ns/1ps

module isp_exposure_top (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 in_valid,
    input  isp_pkg::request_t    in_req,
    output logic                 out_valid,
    output logic [7:0]           out_data,
    output isp_pkg::axi_addr_t   ar,
    input  logic                 arready,
    input  isp_pkg::axi_rdata_t  r,
    output logic                 rready,
    output isp_pkg::axi_addr_t   aw,
    input  logic                 awready,
    output isp_pkg::axi_wdata_t  w,
    input  logic                 wready,
    input  logic                 bvalid,
    output logic                 bready
);

    logic                  start;
    logic [31:0]           base_addr;
    isp_pkg::ratio_mode_e  ratio;
    isp_pkg::pixel_beat_t  pixel;
    logic                  space;
    logic                  write_done;
    logic                  sum_valid;
    isp_pkg::sum_t         sum;

    exposure_ctrl u_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .in_req     (in_req),
        .write_done (write_done),
        .sum_valid  (sum_valid),
        .sum        (sum),
        .start      (start),
        .base_addr  (base_addr),
        .ratio      (ratio),
        .out_valid  (out_valid),
        .out_data   (out_data)
    );

    dram_read_port u_read (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (start),
        .base_addr (base_addr),
        .ratio     (ratio),
        .ar        (ar),
        .arready   (arready),
        .r         (r),
        .rready    (rready),
        .space     (space),
        .pixel     (pixel)
    );

    dram_write_port u_write (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .base_addr  (base_addr),
        .pixel      (pixel),
        .space      (space),
        .aw         (aw),
        .awready    (awready),
        .w          (w),
        .wready     (wready),
        .bvalid     (bvalid),
        .bready     (bready),
        .write_done (write_done)
    );

    brightness_accumulator u_accum (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (start),
        .pixel     (pixel),
        .sum_valid (sum_valid),
        .sum       (sum)
    );

endmodule

/* testbench/dram_model.sv */
`timescale 1ns/1ps
`include "isp_config.svh"

module dram_model (
    input  logic                 clk,
    input  logic                 rst_n,
    input  isp_pkg::axi_addr_t   ar,
    output logic                 arready = 1'b0,
    output isp_pkg::axi_rdata_t  r,
    input  logic                 rready,
    input  isp_pkg::axi_addr_t   aw,
    output logic                 awready = 1'b0,
    input  isp_pkg::axi_wdata_t  w,
    output logic                 wready = 1'b0,
    output logic                 bvalid = 1'b0,
    input  logic                 bready
);

    localparam int MEM_BEATS = `ISP_NUM_PICS * `ISP_BURST_BEATS;
    localparam int LAST_BEAT = `ISP_BURST_BEATS - 1;

    isp_pkg::beat_t  mem [MEM_BEATS];

    // burst and beat counters for the testbench
    int              read_bursts = 0;
    int              read_beats = 0;
    int              write_bursts = 0;
    int              write_beats = 0;
    int              last_errors = 0;

    // length fields of the latest bursts
    logic [7:0]      ar_len_seen = '0;
    logic [7:0]      aw_len_seen = '0;

    logic            ar_hs = 1'b0;
    logic            r_hs = 1'b0;
    logic            aw_hs = 1'b0;
    logic            w_hs = 1'b0;
    logic            b_hs = 1'b0;
    logic [31:0]     ar_addr_q;
    logic [31:0]     aw_addr_q;
    logic [7:0]      ar_len_q;
    logic [7:0]      aw_len_q;
    isp_pkg::beat_t  w_data_q;
    logic            w_last_q;

    logic            filled = 1'b0;
    logic            rvalid = 1'b0;
    logic            rd_active = 1'b0;
    logic            wr_active = 1'b0;
    logic            b_pending = 1'b0;
    int              rd_base = 0;
    int              rd_cnt = 0;
    int              wr_base = 0;
    int              wr_cnt = 0;

    assign r = '{data:  rd_active ? mem[rd_base + rd_cnt] : '0,
                 last:  (rd_cnt == LAST_BEAT),
                 valid: rvalid};

    task automatic fill_memory();
        for (int i = 0; i < MEM_BEATS; i++) begin
            for (int j = 0; j < 16; j++) begin
                mem[i][j] = 8'($urandom);
            end
        end
    endtask

    task automatic read_beat(input int idx, output isp_pkg::beat_t data);
        data = mem[idx];
    endtask

    // handshakes as seen on the rising edge
    always @(posedge clk) begin
        ar_hs     <= ar.valid && arready;
        r_hs      <= r.valid && rready;
        aw_hs     <= aw.valid && awready;
        w_hs      <= w.valid && wready;
        b_hs      <= bvalid && bready;
        ar_addr_q <= ar.addr;
        aw_addr_q <= aw.addr;
        ar_len_q  <= ar.len;
        aw_len_q  <= aw.len;
        w_data_q  <= w.data;
        w_last_q  <= w.last;
    end

    // ========================================
    // slave side driven on the falling edge
    // ========================================
    always @(negedge clk) begin
        if (!rst_n) begin
            if (!filled) begin
                fill_memory();
                filled = 1'b1;
            end
            arready   = 1'b0;
            awready   = 1'b0;
            wready    = 1'b0;
            bvalid    = 1'b0;
            rvalid    = 1'b0;
            rd_active = 1'b0;
            wr_active = 1'b0;
            b_pending = 1'b0;
        end else begin
            if (ar_hs) begin
                rd_base     = int'((ar_addr_q - `ISP_DRAM_BASE) >> 4);
                rd_cnt      = 0;
                rd_active   = 1'b1;
                ar_len_seen = ar_len_q;
                read_bursts++;
            end
            if (r_hs) begin
                read_beats++;
                if (rd_cnt == LAST_BEAT) rd_active = 1'b0;
                rd_cnt++;
            end
            // valid holds until its beat is taken
            if (r_hs || !rvalid) begin
                rvalid = rd_active && (($urandom % 4) != 0);
            end
            arready = ($urandom % 4) != 0;

            if (aw_hs) begin
                wr_base     = int'((aw_addr_q - `ISP_DRAM_BASE) >> 4);
                wr_cnt      = 0;
                wr_active   = 1'b1;
                aw_len_seen = aw_len_q;
                write_bursts++;
            end
            if (w_hs) begin
                mem[wr_base + wr_cnt] = w_data_q;
                write_beats++;
                if (w_last_q != (wr_cnt == LAST_BEAT)) last_errors++;
                if (wr_cnt == LAST_BEAT) begin
                    wr_active = 1'b0;
                    b_pending = 1'b1;
                end
                wr_cnt++;
            end
            // data only after its address
            wready  = wr_active && (($urandom % 4) != 0);
            awready = ($urandom % 4) != 0;

            if (b_hs) begin
                bvalid = 1'b0;
            end else if (b_pending && !bvalid && (($urandom % 2) != 0)) begin
                bvalid    = 1'b1;
                b_pending = 1'b0;
            end
        end
    end

endmodule

/* testbench/tb_isp_exposure.sv */
`timescale 1ns/1ps
`include "isp_config.svh"

module tb_isp_exposure;

    localparam int NUM_REQUESTS = 40;
    localparam int PIC_BEATS    = `ISP_BURST_BEATS;
    localparam int MEM_BEATS    = `ISP_NUM_PICS * `ISP_BURST_BEATS;
    localparam int CYCLE_LIMIT  = NUM_REQUESTS * `ISP_BURST_BEATS * 4 + 1000;

    logic                 clk = 1'b0;
    logic                 rst_n;
    logic                 in_valid;
    isp_pkg::request_t    in_req;
    logic                 out_valid;
    logic [7:0]           out_data;
    isp_pkg::axi_addr_t   ar;
    logic                 arready;
    isp_pkg::axi_rdata_t  r;
    logic                 rready;
    isp_pkg::axi_addr_t   aw;
    logic                 awready;
    isp_pkg::axi_wdata_t  w;
    logic                 wready;
    logic                 bvalid;
    logic                 bready;

    // reference pictures and result record
    isp_pkg::beat_t       ref_mem [MEM_BEATS];
    logic [7:0]           rec_data [`ISP_NUM_PICS];
    logic                 rec_valid [`ISP_NUM_PICS];

    int                   result_errors = 0;
    int                   beat_errors = 0;
    int                   flag_errors = 0;
    int                   cycles = 0;

    always #5 clk = ~clk;

    isp_exposure_top dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_req    (in_req),
        .out_valid (out_valid),
        .out_data  (out_data),
        .ar        (ar),
        .arready   (arready),
        .r         (r),
        .rready    (rready),
        .aw        (aw),
        .awready   (awready),
        .w         (w),
        .wready    (wready),
        .bvalid    (bvalid),
        .bready    (bready)
    );

    dram_model mem_model (
        .clk     (clk),
        .rst_n   (rst_n),
        .ar      (ar),
        .arready (arready),
        .r       (r),
        .rready  (rready),
        .aw      (aw),
        .awready (awready),
        .w       (w),
        .wready  (wready),
        .bvalid  (bvalid),
        .bready  (bready)
    );

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Finished with errors");
            $finish;
        end
    end

    // ========================================
    // compare tasks
    // ========================================
    task automatic check_result(input logic [7:0] got, input logic [7:0] exp,
                                input string what);
        if (got !== exp) begin
            result_errors++;
            $display("MISMATCH at %0t: %s, got %0d expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_beat(input isp_pkg::beat_t got, input isp_pkg::beat_t exp,
                              input string what);
        if (got !== exp) begin
            beat_errors++;
            $display("MISMATCH at %0t: %s, got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            flag_errors++;
            $display("MISMATCH at %0t: %s, got %0b expected %0b", $time, what, got, exp);
        end
    endtask

    // ========================================
    // reference model
    // ========================================
    function automatic logic [7:0] scaled_value(input logic [7:0] b,
                                                input isp_pkg::ratio_mode_e mode);
        int v;
        v = int'(b);
        case (mode)
            isp_pkg::ratio_quarter: v = v / 4;
            isp_pkg::ratio_half:    v = v / 2;
            isp_pkg::ratio_double:  v = (2 * v > 255) ? 255 : 2 * v;
            default:                v = v;
        endcase
        return 8'(v);
    endfunction

    // scales the picture in place and returns its grey average
    task automatic apply_reference(input isp_pkg::pic_no_t pic,
                                   input isp_pkg::ratio_mode_e mode,
                                   output logic [7:0] avg);
        int sum;
        int idx;
        int v;
        sum = 0;
        for (int k = 0; k < PIC_BEATS; k++) begin
            idx = int'(pic) * PIC_BEATS + k;
            for (int j = 0; j < 16; j++) begin
                ref_mem[idx][j] = scaled_value(ref_mem[idx][j], mode);
                v = int'(ref_mem[idx][j]);
                sum += (k / `ISP_BEATS_PER_CHANNEL == 1) ? v / 2 : v / 4;
            end
        end
        avg = 8'(sum >> `ISP_AVG_SHIFT);
    endtask

    task automatic run_request(input isp_pkg::pic_no_t pic, input isp_pkg::ratio_mode_e mode);
        logic [7:0]      expected;
        logic            hit;
        int              rb;
        int              rbe;
        int              wb;
        int              wbe;
        int              le;
        isp_pkg::beat_t  actual;
        string           tag;
        tag = $sformatf("picture %0d ratio %s", pic, mode.name());
        hit = (mode == isp_pkg::ratio_unity) && rec_valid[pic];
        if (hit) begin
            expected = rec_data[pic];
        end else begin
            apply_reference(pic, mode, expected);
            rec_valid[pic] = 1'b1;
            rec_data[pic]  = expected;
        end
        rb  = mem_model.read_bursts;
        rbe = mem_model.read_beats;
        wb  = mem_model.write_bursts;
        wbe = mem_model.write_beats;
        le  = mem_model.last_errors;

        @(negedge clk);
        in_valid = 1'b1;
        in_req   = '{pic_no: pic, ratio: mode};
        @(negedge clk);
        in_valid = 1'b0;
        while (!out_valid) @(negedge clk);
        check_result(out_data, expected, {tag, " result"});

        if (hit) begin
            check_flag(mem_model.read_bursts == rb, 1'b1, {tag, " hit caused a read"});
            check_flag(mem_model.write_bursts == wb, 1'b1, {tag, " hit caused a write"});
        end else begin
            check_flag(mem_model.read_bursts - rb == 1, 1'b1, {tag, " one read burst"});
            check_flag(mem_model.write_bursts - wb == 1, 1'b1, {tag, " one write burst"});
            check_flag(mem_model.read_beats - rbe == PIC_BEATS, 1'b1, {tag, " read beats"});
            check_flag(mem_model.write_beats - wbe == PIC_BEATS, 1'b1, {tag, " write beats"});
            check_result(mem_model.ar_len_seen, 8'(PIC_BEATS - 1), {tag, " ar length"});
            check_result(mem_model.aw_len_seen, 8'(PIC_BEATS - 1), {tag, " aw length"});
            check_flag(mem_model.last_errors == le, 1'b1, {tag, " w last on the final beat"});
            for (int k = 0; k < PIC_BEATS; k++) begin
                mem_model.read_beat(int'(pic) * PIC_BEATS + k, actual);
                check_beat(actual, ref_mem[int'(pic) * PIC_BEATS + k],
                           $sformatf("%s beat %0d", tag, k));
            end
        end
    endtask

    initial begin
        isp_pkg::pic_no_t      pic;
        isp_pkg::ratio_mode_e  mode;
        int                    total;
        void'($urandom(56719));
        in_valid = 1'b0;
        in_req   = '0;
        rst_n    = 1'b0;
        for (int p = 0; p < `ISP_NUM_PICS; p++) begin
            rec_valid[p] = 1'b0;
            rec_data[p]  = 8'd0;
        end
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        check_flag(out_valid, 1'b0, "out_valid after reset");
        check_flag(ar.valid, 1'b0, "ar valid after reset");
        check_flag(aw.valid, 1'b0, "aw valid after reset");
        check_flag(w.valid, 1'b0, "w valid after reset");

        for (int i = 0; i < MEM_BEATS; i++) begin
            mem_model.read_beat(i, ref_mem[i]);
        end

        // one miss per ratio mode and a record hit
        run_request(4'd0, isp_pkg::ratio_quarter);
        run_request(4'd1, isp_pkg::ratio_half);
        run_request(4'd2, isp_pkg::ratio_unity);
        run_request(4'd3, isp_pkg::ratio_double);
        run_request(4'd0, isp_pkg::ratio_unity);

        for (int n = 5; n < NUM_REQUESTS; n++) begin
            pic  = 4'($urandom % `ISP_NUM_PICS);
            mode = isp_pkg::ratio_mode_e'(2'($urandom % 4));
            run_request(pic, mode);
        end

        total = result_errors + beat_errors + flag_errors;
        $display("errors: %0d result, %0d beat, %0d flag", result_errors, beat_errors,
                 flag_errors);
        if (total == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

/* files.f */
+incdir+rtl
rtl/isp_pkg.sv
rtl/exposure_ctrl.sv
rtl/dram_read_port.sv
rtl/dram_write_port.sv
rtl/brightness_accumulator.sv
rtl/isp_exposure_top.sv
testbench/dram_model.sv
testbench/tb_isp_exposure.sv

/* Makefile */
TOP = tb_isp_exposure

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f files.f --top-module $(TOP)

sim:
	verilator --binary --timing -f files.f --top-module $(TOP) -Mdir obj_dir
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; \
	echo "$$out" | grep -q "^Finished with no errors$$"

clean:
	rm -rf obj_dir
